// ==== sim.f ====
+incdir+verification
verilog/isa_pkg.sv
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_operands.sv
verilog/id_sequencer.sv
verilog/id_stage.sv
verification/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_id_stage -o tb_sim \
  && ./obj_dir/tb_sim | grep "NO ERRORS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== verification/tb_id_vectors.svh ====
// Decode stage test vectors
// One row per instruction word with its stimulus and expected decode results

`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// Operand A sources
localparam logic [1:0] A_REG  = 2'd0;
localparam logic [1:0] A_LAST = 2'd1;
localparam logic [1:0] A_PC   = 2'd2;
localparam logic [1:0] A_ZERO = 2'd3;

// Operand B sources
localparam logic [2:0] B_REG   = 3'd0;
localparam logic [2:0] B_IMM_I = 3'd1;
localparam logic [2:0] B_IMM_S = 3'd2;
localparam logic [2:0] B_IMM_B = 3'd3;
localparam logic [2:0] B_IMM_U = 3'd4;
localparam logic [2:0] B_IMM_J = 3'd5;
localparam logic [2:0] B_FOUR  = 3'd6;

// Instruction kinds that set the timing
localparam logic [1:0] K_ALU = 2'd0;
localparam logic [1:0] K_BR  = 2'd1;
localparam logic [1:0] K_JMP = 2'd2;
localparam logic [1:0] K_MEM = 2'd3;

typedef struct packed {
  logic [31:0] word;
  logic        taken;
  logic [1:0]  delay;
  logic        misal;
  alu_op_e     alu_op;
  logic [1:0]  a_src;
  logic [2:0]  b_src;
  logic [4:0]  waddr;
  logic        we;
  logic [2:0]  cycles;
  logic        ill;
  logic [1:0]  kind;
  logic        lsu_we;
  logic [1:0]  lsu_type;
  logic        lsu_sext;
} vec_t;

localparam int NUM_VEC   = 21;
localparam int MAX_DELAY = 3;

// First line: word, taken, delay, misal
// Second line: op, A, B, rd, we, cycles, ill, kind, st, type, sext
localparam vec_t VECS [NUM_VEC] = '{
  '{32'h002081B3, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_REG, B_REG, 5'd3, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h407302B3, 1'b0, 2'd0, 1'b0,
    ALU_SUB, A_REG, B_REG, 5'd5, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h40945233, 1'b0, 2'd0, 1'b0,
    ALU_SRA, A_REG, B_REG, 5'd4, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h00C5B533, 1'b0, 2'd0, 1'b0,
    ALU_SLTU, A_REG, B_REG, 5'd10, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'hFFB10093, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_REG, B_IMM_I, 5'd1, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h1233C313, 1'b0, 2'd0, 1'b0,
    ALU_XOR, A_REG, B_IMM_I, 5'd6, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h4071D113, 1'b0, 2'd0, 1'b0,
    ALU_SRA, A_REG, B_IMM_I, 5'd2, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'hABCDE3B7, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_ZERO, B_IMM_U, 5'd7, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h12345417, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_PC, B_IMM_U, 5'd8, 1'b1, 3'd1, 1'b0, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h00208863, 1'b0, 2'd0, 1'b0,
    ALU_EQ, A_PC, B_IMM_B, 5'd16, 1'b0, 3'd1, 1'b0, K_BR, 1'b0, 2'd0, 1'b0},
  '{32'hFE419CE3, 1'b1, 2'd0, 1'b0,
    ALU_NE, A_PC, B_IMM_B, 5'd25, 1'b0, 3'd2, 1'b0, K_BR, 1'b0, 2'd0, 1'b0},
  '{32'h0262E063, 1'b1, 2'd0, 1'b0,
    ALU_LTU, A_PC, B_IMM_B, 5'd0, 1'b0, 3'd2, 1'b0, K_BR, 1'b0, 2'd0, 1'b0},
  '{32'h100000EF, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_PC, B_IMM_J, 5'd1, 1'b1, 3'd2, 1'b0, K_JMP, 1'b0, 2'd0, 1'b0},
  '{32'h00812283, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_REG, B_IMM_I, 5'd5, 1'b1, 3'd2, 1'b0, K_MEM, 1'b0, 2'd0, 1'b1},
  '{32'h00324303, 1'b0, 2'd2, 1'b0,
    ALU_ADD, A_REG, B_IMM_I, 5'd6, 1'b1, 3'd4, 1'b0, K_MEM, 1'b0, 2'd2, 1'b0},
  '{32'hFFE09383, 1'b0, 2'd1, 1'b1,
    ALU_ADD, A_LAST, B_FOUR, 5'd7, 1'b1, 3'd3, 1'b0, K_MEM, 1'b0, 2'd1, 1'b1},
  '{32'h00942623, 1'b0, 2'd3, 1'b0,
    ALU_ADD, A_REG, B_IMM_S, 5'd12, 1'b0, 3'd5, 1'b0, K_MEM, 1'b1, 2'd0, 1'b0},
  '{32'hFE310FA3, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_REG, B_IMM_S, 5'd31, 1'b0, 3'd2, 1'b0, K_MEM, 1'b1, 2'd2, 1'b0},
  '{32'h0000007F, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_REG, B_REG, 5'd0, 1'b0, 3'd1, 1'b1, K_ALU, 1'b0, 2'd0, 1'b0},
  '{32'h002088B3, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_REG, B_REG, 5'd17, 1'b0, 3'd1, 1'b1, K_ALU, 1'b0, 2'd0, 1'b0},
  // Load from x20 is illegal and must not request memory
  '{32'h000A2283, 1'b0, 2'd0, 1'b0,
    ALU_ADD, A_REG, B_IMM_I, 5'd5, 1'b0, 3'd1, 1'b1, K_ALU, 1'b0, 2'd0, 1'b0}
};

`endif

// ==== verification/tb_id_stage.sv ====
// Testbench for the RV32I decode stage
// Applies the vector table, models the memory response and checks each cycle

`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  import isa_pkg::*;
  import id_pkg::*;

  `include "tb_id_vectors.svh"

  localparam time CLK_PERIOD    = 40;
  // Reset plus the longest possible instruction for every vector
  localparam time WATCHDOG_TIME = (NUM_VEC * (MAX_DELAY + 10) + 4) * CLK_PERIOD;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        instr_valid_i;
  instr_u      instr;
  logic [31:0] pc_i;
  logic [31:0] rf_rdata_a_i;
  logic [31:0] rf_rdata_b_i;
  logic        branch_decision_i;
  logic        lsu_resp_valid_i;
  logic        lsu_addr_incr_req_i;
  logic [31:0] lsu_addr_last_i;
  alu_op_e     alu_operator_o;
  logic [31:0] alu_operand_a_o;
  logic [31:0] alu_operand_b_o;
  lsu_ctrl_t   lsu_o;
  logic [31:0] lsu_wdata_o;
  logic [4:0]  rf_raddr_a_o;
  logic [4:0]  rf_raddr_b_o;
  logic        rf_ren_a_o;
  logic        rf_ren_b_o;
  logic [4:0]  rf_waddr_o;
  logic        rf_we_o;
  logic        branch_set_o;
  logic        jump_set_o;
  logic        illegal_insn_o;
  logic        instr_done_o;
  logic [31:0] rng_state;

  id_stage #(
    .RV32E (1'b1)
  ) i_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .instr_i             (instr),
    .pc_i                (pc_i),
    .rf_rdata_a_i        (rf_rdata_a_i),
    .rf_rdata_b_i        (rf_rdata_b_i),
    .branch_decision_i   (branch_decision_i),
    .lsu_resp_valid_i    (lsu_resp_valid_i),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .alu_operator_o      (alu_operator_o),
    .alu_operand_a_o     (alu_operand_a_o),
    .alu_operand_b_o     (alu_operand_b_o),
    .lsu_o               (lsu_o),
    .lsu_wdata_o         (lsu_wdata_o),
    .rf_raddr_a_o        (rf_raddr_a_o),
    .rf_raddr_b_o        (rf_raddr_b_o),
    .rf_ren_a_o          (rf_ren_a_o),
    .rf_ren_b_o          (rf_ren_b_o),
    .rf_waddr_o          (rf_waddr_o),
    .rf_we_o             (rf_we_o),
    .branch_set_o        (branch_set_o),
    .jump_set_o          (jump_set_o),
    .illegal_insn_o      (illegal_insn_o),
    .instr_done_o        (instr_done_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure();
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      report_failure();
    end
  endtask

  function automatic logic [31:0] expected_a(input vec_t v);
    case (v.a_src)
      A_REG:   return rf_rdata_a_i;
      A_LAST:  return lsu_addr_last_i;
      A_PC:    return pc_i;
      default: return 32'h0;
    endcase
  endfunction

  // Immediates rebuilt from the ISA bit layout
  function automatic logic [31:0] expected_b(input vec_t v);
    logic [31:0] w;
    w = v.word;
    case (v.b_src)
      B_REG:   return rf_rdata_b_i;
      B_IMM_I: return {{20{w[31]}}, w[31:20]};
      B_IMM_S: return {{20{w[31]}}, w[31:25], w[11:7]};
      B_IMM_B: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      B_IMM_U: return {w[31:12], 12'h000};
      B_IMM_J: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: return 32'h4;
    endcase
  endfunction

  // R, S and B formats read both registers, I formats only rs1
  function automatic logic [1:0] expected_ren(input vec_t v);
    if (v.ill) begin
      return 2'b00;
    end
    case (v.word[6:0])
      OPC_OP, OPC_STORE, OPC_BRANCH:  return 2'b11;
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: return 2'b10;
      default:                        return 2'b00;
    endcase
  endfunction

  task automatic check_cycle(input vec_t v, input int cyc);
    logic       last;
    logic [1:0] ren;
    last = (cyc == int'(v.cycles) - 1);
    ren  = expected_ren(v);
    check_val("instr_done_o", 32'(instr_done_o), 32'(last));
    check_val("rf_we_o", 32'(rf_we_o), 32'(last & v.we));
    check_val("lsu_o.req", 32'(lsu_o.req), 32'((v.kind == K_MEM) && (cyc == 0)));
    check_val("jump_set_o", 32'(jump_set_o), 32'((v.kind == K_JMP) && (cyc == 0)));
    // Branch set comes one cycle late, only when taken
    check_val("branch_set_o", 32'(branch_set_o),
              32'((v.kind == K_BR) && v.taken && (cyc == 1)));
    check_val("illegal_insn_o", 32'(illegal_insn_o), 32'(v.ill));
    if (cyc == 0) begin
      check_val("alu_operator_o", 32'(alu_operator_o), 32'(v.alu_op));
      check_val("alu_operand_a_o", alu_operand_a_o, expected_a(v));
      check_val("alu_operand_b_o", alu_operand_b_o, expected_b(v));
      check_val("rf_waddr_o", 32'(rf_waddr_o), 32'(v.waddr));
      // Read addresses are the raw rs1 and rs2 fields
      check_val("rf_raddr_a_o", 32'(rf_raddr_a_o), 32'(v.word[19:15]));
      check_val("rf_raddr_b_o", 32'(rf_raddr_b_o), 32'(v.word[24:20]));
      check_val("rf_ren_a_o", 32'(rf_ren_a_o), 32'(ren[1]));
      check_val("rf_ren_b_o", 32'(rf_ren_b_o), 32'(ren[0]));
      if (v.kind == K_MEM) begin
        check_val("lsu_o.we", 32'(lsu_o.we), 32'(v.lsu_we));
        check_val("lsu_o.data_type", 32'(lsu_o.data_type), 32'(v.lsu_type));
        check_val("lsu_o.sign_ext", 32'(lsu_o.sign_ext), 32'(v.lsu_sext));
        check_val("lsu_wdata_o", lsu_wdata_o, rf_rdata_b_i);
      end
    end
  endtask

  // Drives one vector and follows it until the done strobe
  task automatic run_vector(input vec_t v);
    int   cyc;
    logic done_seen;
    @(negedge clk_i);
    instr               = v.word;
    rng_state           = xorshift32(rng_state);
    pc_i                = rng_state;
    rng_state           = xorshift32(rng_state);
    rf_rdata_a_i        = rng_state;
    rng_state           = xorshift32(rng_state);
    rf_rdata_b_i        = rng_state;
    rng_state           = xorshift32(rng_state);
    lsu_addr_last_i     = rng_state;
    branch_decision_i   = v.taken;
    lsu_addr_incr_req_i = v.misal;
    instr_valid_i       = 1'b1;
    cyc                 = 0;
    done_seen           = 1'b0;
    while (!done_seen) begin
      if (cyc > 0) begin
        @(negedge clk_i);
      end
      // Memory answers delay cycles after the request cycle
      lsu_resp_valid_i = (v.kind == K_MEM) && (cyc == 1 + int'(v.delay));
      #(CLK_PERIOD / 4);
      check_cycle(v, cyc);
      done_seen = instr_done_o;
      cyc++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rng_state           = 32'd93412;
    rst_ni              = 1'b0;
    instr_valid_i       = 1'b0;
    instr               = '0;
    pc_i                = '0;
    rf_rdata_a_i        = '0;
    rf_rdata_b_i        = '0;
    branch_decision_i   = 1'b0;
    lsu_resp_valid_i    = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    lsu_addr_last_i     = '0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int n = 0; n < NUM_VEC; n++) begin
      run_vector(VECS[n]);
    end
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the stage never finished the vector table");
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
// RV32I decode stage top level
// Joins the decoder, the operand builder and the stage sequencer

`timescale 1ns/1ps
`default_nettype none

module id_stage #(
  parameter bit RV32E = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  isa_pkg::instr_u                     instr_i,
  input  logic [isa_pkg::XLEN-1:0]            pc_i,
  input  logic [isa_pkg::XLEN-1:0]            rf_rdata_a_i,
  input  logic [isa_pkg::XLEN-1:0]            rf_rdata_b_i,
  input  logic                                branch_decision_i,
  input  logic                                lsu_resp_valid_i,
  input  logic                                lsu_addr_incr_req_i,
  input  logic [isa_pkg::XLEN-1:0]            lsu_addr_last_i,
  output id_pkg::alu_op_e                     alu_operator_o,
  output logic [isa_pkg::XLEN-1:0]            alu_operand_a_o,
  output logic [isa_pkg::XLEN-1:0]            alu_operand_b_o,
  output id_pkg::lsu_ctrl_t                   lsu_o,
  output logic [isa_pkg::XLEN-1:0]            lsu_wdata_o,
  output logic [isa_pkg::REG_ADDR_W-1:0]      rf_raddr_a_o,
  output logic [isa_pkg::REG_ADDR_W-1:0]      rf_raddr_b_o,
  output logic                                rf_ren_a_o,
  output logic                                rf_ren_b_o,
  output logic [isa_pkg::REG_ADDR_W-1:0]      rf_waddr_o,
  output logic                                rf_we_o,
  output logic                                branch_set_o,
  output logic                                jump_set_o,
  output logic                                illegal_insn_o,
  output logic                                instr_done_o
);

  import id_pkg::*;

  dec_ctrl_t dec_ctrl;
  logic      illegal_dec;
  logic      rf_ren_a_dec;
  logic      rf_ren_b_dec;
  logic      lsu_req;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  id_decoder #(
    .RV32E (RV32E)
  ) i_decoder (
    .instr_i      (instr_i),
    .ctrl_o       (dec_ctrl),
    .rf_raddr_a_o (rf_raddr_a_o),
    .rf_raddr_b_o (rf_raddr_b_o),
    .rf_waddr_o   (rf_waddr_o),
    .rf_ren_a_o   (rf_ren_a_dec),
    .rf_ren_b_o   (rf_ren_b_dec),
    .illegal_o    (illegal_dec)
  );

  // Legality is folded in by the decoder, validity here
  assign rf_ren_a_o     = instr_valid_i & rf_ren_a_dec;
  assign rf_ren_b_o     = instr_valid_i & rf_ren_b_dec;
  assign illegal_insn_o = instr_valid_i & illegal_dec;

  //////////////////////////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////////////////////////

  id_operands i_operands (
    .clk_i               (clk_i),
    .instr_valid_i       (instr_valid_i),
    .instr_i             (instr_i),
    .ctrl_i              (dec_ctrl),
    .pc_i                (pc_i),
    .rf_rdata_a_i        (rf_rdata_a_i),
    .rf_rdata_b_i        (rf_rdata_b_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .alu_operand_a_o     (alu_operand_a_o),
    .alu_operand_b_o     (alu_operand_b_o)
  );

  assign alu_operator_o = dec_ctrl.alu_op;

  //////////////////////////////////////////////////////////////////////
  // Sequencing and LSU request
  //////////////////////////////////////////////////////////////////////

  id_sequencer i_sequencer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .illegal_i         (illegal_dec),
    .ctrl_i            (dec_ctrl),
    .branch_decision_i (branch_decision_i),
    .lsu_resp_valid_i  (lsu_resp_valid_i),
    .lsu_req_o         (lsu_req),
    .branch_set_o      (branch_set_o),
    .jump_set_o        (jump_set_o),
    .rf_we_o           (rf_we_o),
    .instr_done_o      (instr_done_o)
  );

  // Request comes from the sequencer, the access fields from the decoder
  always_comb begin
    lsu_o     = dec_ctrl.lsu;
    lsu_o.req = lsu_req;
  end

  // Store data is rs2 straight from the register file
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

`default_nettype wire

// ==== verilog/id_sequencer.sv ====
// Decode stage sequencer
// Two-state FSM that stalls taken branches, jumps and memory accesses and
// produces the set pulses, the LSU request and the done strobe

`timescale 1ns/1ps
`default_nettype none

module id_sequencer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_valid_i,
  input  logic              illegal_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  logic              branch_decision_i,
  input  logic              lsu_resp_valid_i,
  output logic              lsu_req_o,
  output logic              branch_set_o,
  output logic              jump_set_o,
  output logic              rf_we_o,
  output logic              instr_done_o
);

  import id_pkg::*;

  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       first_cycle;
  logic       branch_set_q;
  logic       branch_set_d;
  logic       stall_mem;
  logic       stall_branch;
  logic       stall_jump;
  logic       stall;

  assign first_cycle = instr_valid_i & (state_q == FIRST_CYCLE);

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_o   = 1'b0;

    if (instr_valid_i) begin
      unique case (state_q)
        FIRST_CYCLE: begin
          if (ctrl_i.lsu.req) begin
            state_d = MULTI_CYCLE;
          end else if (ctrl_i.branch) begin
            // Not-taken branch finishes right away
            state_d      = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl_i.jump) begin
            state_d    = MULTI_CYCLE;
            stall_jump = 1'b1;
            jump_set_o = 1'b1;
          end
        end
        // Branch and jump end here, memory ops wait for the response
        default: state_d = stall_mem ? MULTI_CYCLE : FIRST_CYCLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
    end else begin
      // Branch set goes out one cycle after the decision
      branch_set_q <= branch_set_d;
      if (instr_valid_i) begin
        state_q <= state_d;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stalls and gated outputs
  //////////////////////////////////////////////////////////////////////

  // Memory ops always stall the request cycle, then until the response
  assign stall_mem = instr_valid_i & ctrl_i.lsu.req & (~lsu_resp_valid_i | first_cycle);
  assign stall     = stall_mem | stall_branch | stall_jump;

  assign instr_done_o = instr_valid_i & ~stall;
  assign lsu_req_o    = ctrl_i.lsu.req & first_cycle;
  assign branch_set_o = branch_set_q;
  assign rf_we_o      = instr_done_o & ctrl_i.rf_we & ~illegal_i;

  // Decoder flags at most one multicycle kind
  seq_kind_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({ctrl_i.branch, ctrl_i.jump, ctrl_i.lsu.req}));

  seq_multi_stalls_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_valid_i && state_q == FIRST_CYCLE && state_d == MULTI_CYCLE |-> stall);

  // Illegal words finish in their first cycle
  seq_illegal_no_stall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_valid_i && illegal_i |-> !stall);

endmodule

`default_nettype wire

// ==== verilog/id_operands.sv ====
// ALU operand builder
// Sign-extends the immediates and muxes operands A and B, with the
// second-address override for misaligned loads and stores

`timescale 1ns/1ps
`default_nettype none

module id_operands (
  input  logic                      clk_i,
  input  logic                      instr_valid_i,
  input  isa_pkg::instr_u           instr_i,
  input  id_pkg::dec_ctrl_t         ctrl_i,
  input  logic [isa_pkg::XLEN-1:0]  pc_i,
  input  logic [isa_pkg::XLEN-1:0]  rf_rdata_a_i,
  input  logic [isa_pkg::XLEN-1:0]  rf_rdata_b_i,
  input  logic [isa_pkg::XLEN-1:0]  lsu_addr_last_i,
  input  logic                      lsu_addr_incr_req_i,
  output logic [isa_pkg::XLEN-1:0]  alu_operand_a_o,
  output logic [isa_pkg::XLEN-1:0]  alu_operand_b_o
);

  import isa_pkg::*;
  import id_pkg::*;

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;
  logic [XLEN-1:0] imm_b;
  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_b_sel;

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  assign imm_i_type = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  // S, B, U and J fields are scattered over the raw word
  assign imm_s_type = {{20{instr_i.raw[31]}}, instr_i.raw[31:25], instr_i.raw[11:7]};
  assign imm_b_type = {{19{instr_i.raw[31]}}, instr_i.raw[31], instr_i.raw[7],
                       instr_i.raw[30:25], instr_i.raw[11:8], 1'b0};
  assign imm_u_type = {instr_i.raw[31:12], 12'b0};
  assign imm_j_type = {{12{instr_i.raw[31]}}, instr_i.raw[19:12], instr_i.raw[20],
                       instr_i.raw[30:21], 1'b0};

  // Misaligned second access adds 4 to the last LSU address
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : ctrl_i.op_a_sel;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : ctrl_i.op_b_sel;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : ctrl_i.imm_b_sel;

  //////////////////////////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  // No compressed instructions so both increments are a full word
  always_comb begin
    unique case (imm_b_sel)
      IMM_B_I:         imm_b = imm_i_type;
      IMM_B_S:         imm_b = imm_s_type;
      IMM_B_B:         imm_b = imm_b_type;
      IMM_B_U:         imm_b = imm_u_type;
      IMM_B_J:         imm_b = imm_j_type;
      IMM_B_INCR_PC:   imm_b = 32'h4;
      IMM_B_INCR_ADDR: imm_b = 32'h4;
      default:         imm_b = 32'h4;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

  // Decoder output after the override must name a real immediate
  imm_b_sel_legal_a: assert property (@(posedge clk_i) instr_valid_i |->
      imm_b_sel inside {IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J,
                        IMM_B_INCR_PC, IMM_B_INCR_ADDR});

endmodule

`default_nettype wire

// ==== verilog/id_decoder.sv ====
// RV32I instruction decoder
// Turns one instruction word into the control word, register addresses and
// an illegal flag, with the RV32E register limit as an option

`timescale 1ns/1ps
`default_nettype none

module id_decoder #(
  parameter bit RV32E = 1'b0
) (
  input  isa_pkg::instr_u                     instr_i,
  output id_pkg::dec_ctrl_t                   ctrl_o,
  output logic [isa_pkg::REG_ADDR_W-1:0]      rf_raddr_a_o,
  output logic [isa_pkg::REG_ADDR_W-1:0]      rf_raddr_b_o,
  output logic [isa_pkg::REG_ADDR_W-1:0]      rf_waddr_o,
  output logic                                rf_ren_a_o,
  output logic                                rf_ren_b_o,
  output logic                                illegal_o
);

  import isa_pkg::*;
  import id_pkg::*;

  dec_ctrl_t  ctrl;
  logic       ren_a;
  logic       ren_b;
  logic       illegal_enc;
  logic       illegal_reg;
  logic       alt;
  logic       f7_ok;
  logic [2:0] f3;
  logic [1:0] mem_type;

  assign f3    = instr_i.r.funct3;
  // funct7 of 0x20 selects SUB and SRA
  assign alt   = instr_i.r.funct7 == F7_ALT;
  assign f7_ok = (instr_i.r.funct7 == F7_BASE) | alt;

  // Byte, half and word map to 10, 01 and 00
  assign mem_type = {~f3[1] & ~f3[0], f3[0]};

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // All-zero word is ADD on register operands with nothing enabled
    ctrl        = '0;
    ren_a       = 1'b0;
    ren_b       = 1'b0;
    illegal_enc = 1'b0;

    unique case (instr_i.r.opcode)
      OPC_OP, OPC_OP_IMM: begin
        ctrl.rf_we = 1'b1;
        ren_a      = 1'b1;
        unique case (f3)
          F3_ADD:  ctrl.alu_op = (instr_i.r.opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
          F3_SLL:  ctrl.alu_op = ALU_SLL;
          F3_SLT:  ctrl.alu_op = ALU_SLT;
          F3_SLTU: ctrl.alu_op = ALU_SLTU;
          F3_XOR:  ctrl.alu_op = ALU_XOR;
          F3_SR:   ctrl.alu_op = alt ? ALU_SRA : ALU_SRL;
          F3_OR:   ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
        if (instr_i.r.opcode == OPC_OP) begin
          ren_b = 1'b1;
          // Only ADD and the right shift have an alternate form
          illegal_enc = ~f7_ok | (alt & (f3 != F3_ADD) & (f3 != F3_SR));
        end else begin
          ctrl.op_b_sel  = OP_B_IMM;
          ctrl.imm_b_sel = IMM_B_I;
          // Shift immediates keep funct7 in the upper bits
          if (f3 == F3_SLL) begin
            illegal_enc = instr_i.r.funct7 != F7_BASE;
          end else if (f3 == F3_SR) begin
            illegal_enc = ~f7_ok;
          end
        end
      end

      OPC_LUI, OPC_AUIPC: begin
        ctrl.rf_we     = 1'b1;
        ctrl.op_a_sel  = (instr_i.r.opcode == OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMM_B_U;
      end

      OPC_LOAD: begin
        ctrl.rf_we              = 1'b1;
        ctrl.op_b_sel           = OP_B_IMM;
        ctrl.lsu.req            = 1'b1;
        ctrl.lsu.data_type      = mem_type;
        ctrl.lsu.sign_ext       = ~f3[2];
        ren_a                   = 1'b1;
        illegal_enc = !(f3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
      end

      OPC_STORE: begin
        ctrl.op_b_sel      = OP_B_IMM;
        ctrl.imm_b_sel     = IMM_B_S;
        ctrl.lsu.req       = 1'b1;
        ctrl.lsu.we        = 1'b1;
        ctrl.lsu.data_type = mem_type;
        ren_a              = 1'b1;
        ren_b              = 1'b1;
        illegal_enc        = !(f3 inside {F3_B, F3_H, F3_W});
      end

      OPC_BRANCH: begin
        // ALU adds PC and offset, the comparison travels as the operator
        ctrl.branch    = 1'b1;
        ctrl.op_a_sel  = OP_A_CURRPC;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMM_B_B;
        ren_a          = 1'b1;
        ren_b          = 1'b1;
        unique case (f3)
          F3_BEQ:  ctrl.alu_op = ALU_EQ;
          F3_BNE:  ctrl.alu_op = ALU_NE;
          F3_BLT:  ctrl.alu_op = ALU_LT;
          F3_BGE:  ctrl.alu_op = ALU_GE;
          F3_BLTU: ctrl.alu_op = ALU_LTU;
          F3_BGEU: ctrl.alu_op = ALU_GEU;
          default: illegal_enc = 1'b1;
        endcase
      end

      OPC_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.rf_we     = 1'b1;
        ctrl.op_a_sel  = OP_A_CURRPC;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMM_B_J;
      end

      OPC_JALR: begin
        ctrl.jump     = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.op_b_sel = OP_B_IMM;
        ren_a         = 1'b1;
        illegal_enc   = f3 != 3'b000;
      end

      default: illegal_enc = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Legality and outputs
  //////////////////////////////////////////////////////////////////////

  // x16 to x31 do not exist on RV32E
  assign illegal_reg = RV32E & ((ren_a & instr_i.r.rs1[REG_ADDR_W-1]) |
                                (ren_b & instr_i.r.rs2[REG_ADDR_W-1]) |
                                (ctrl.rf_we & instr_i.r.rd[REG_ADDR_W-1]));

  assign illegal_o = illegal_enc | illegal_reg;

  // Illegal words never start a branch, jump or memory access
  always_comb begin
    ctrl_o         = ctrl;
    ctrl_o.branch  = ctrl.branch & ~illegal_o;
    ctrl_o.jump    = ctrl.jump & ~illegal_o;
    ctrl_o.lsu.req = ctrl.lsu.req & ~illegal_o;
  end

  assign rf_raddr_a_o = instr_i.r.rs1;
  assign rf_raddr_b_o = instr_i.r.rs2;
  assign rf_waddr_o   = instr_i.r.rd;
  assign rf_ren_a_o   = ren_a & ~illegal_o;
  assign rf_ren_b_o   = ren_b & ~illegal_o;

endmodule

`default_nettype wire

// ==== verilog/id_pkg.sv ====
// Decode stage types
// ALU operator, operand selects and the control word handed out by the decoder

`default_nettype none

package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // ALU and operand selects
  //////////////////////////////////////////////////////////////////////

  // Zero encodings double as the decoder defaults
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_FWD,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC,
    IMM_B_INCR_ADDR
  } imm_b_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Control words
  //////////////////////////////////////////////////////////////////////

  // Data type 00 word, 01 half, 10 byte
  typedef struct packed {
    logic       req;
    logic       we;
    logic [1:0] data_type;
    logic       sign_ext;
  } lsu_ctrl_t;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       rf_we;
    logic       branch;
    logic       jump;
    lsu_ctrl_t  lsu;
  } dec_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
// RV32I instruction set definitions
// Major opcodes, funct3/funct7 codes and the two views of one instruction word

`default_nettype none

package isa_pkg;

  // Machine word and register index widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  //////////////////////////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // Register and immediate ALU functions
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load and store widths, bit 2 marks the unsigned loads
  localparam logic [2:0] F3_B    = 3'b000;
  localparam logic [2:0] F3_H    = 3'b001;
  localparam logic [2:0] F3_W    = 3'b010;
  localparam logic [2:0] F3_BU   = 3'b100;
  localparam logic [2:0] F3_HU   = 3'b101;

  // funct7 for the base ops and for SUB/SRA
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;

  //////////////////////////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } instr_i_t;

  // Decoder reads the register view, operand builder the immediate and raw views
  typedef union packed {
    instr_r_t         r;
    instr_i_t         i;
    logic [XLEN-1:0]  raw;
  } instr_u;

endpackage

`default_nettype wire
